// File: all.f
hdl/tuple_pkg.sv
hdl/tuple_stream_if.sv
hdl/tuple_unpack.sv
hdl/tuple_fifo.sv
hdl/tuple_adder.sv
hdl/tuple_sum_top.sv
testbench/tb_clock_gen.sv
testbench/tuple_sum_properties.sv
testbench/tb_tuple_sum.sv

// File: hdl/tuple_adder.sv
`timescale 1ns/1ps

// Two-stage adder tree, sixteen fields to four partials to one sum
module tuple_adder (
    input  logic                              aclk,
    input  logic                              reset,

    tuple_stream_if.slave                     tuples,

    output logic                              src_tvalid,
    input  logic                              src_tready,
    output logic [tuple_pkg::FIELD_W-1:0]     src_tdata,
    output logic [tuple_pkg::ID_W-1:0]        src_tid
);

    localparam int GROUPS     = 4;
    localparam int GROUP_SIZE = tuple_pkg::TUPLE_FIELDS / GROUPS;

    logic [GROUPS-1:0][tuple_pkg::FIELD_W-1:0] partial_next;
    logic [GROUPS-1:0][tuple_pkg::FIELD_W-1:0] s1_partial;
    logic [tuple_pkg::ID_W-1:0]                s1_id;
    logic                                      s1_valid;
    logic                                      s1_ready;

    logic [tuple_pkg::FIELD_W-1:0]             total_next;
    tuple_pkg::sum_t                           s2_result;
    logic                                      s2_valid;
    logic                                      s2_ready;

    // Ready chain, an empty stage fills even while the next one stalls
    assign s2_ready     = !s2_valid || src_tready;
    assign s1_ready     = !s1_valid || s2_ready;
    assign tuples.ready = s1_ready;

    // Stage 1 adders, each group covers four neighbouring fields
    always_comb begin
        logic [tuple_pkg::FIELD_W-1:0] acc;
        for (int g = 0; g < GROUPS; g++) begin
            acc = '0;
            for (int f = 0; f < GROUP_SIZE; f++) begin
                acc = acc + tuples.data.fields[g*GROUP_SIZE + f];
            end
            partial_next[g] = acc;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else if (s1_ready) begin
            s1_valid <= tuples.valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (tuples.valid && s1_ready) begin
            s1_partial <= partial_next;
            s1_id      <= tuples.data.id;
        end
    end

    // Stage 2, wraps modulo 2^32
    always_comb begin
        total_next = '0;
        for (int g = 0; g < GROUPS; g++) begin
            total_next = total_next + s1_partial[g];
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            s2_valid <= 1'b0;
        end else if (s2_ready) begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (s1_valid && s2_ready) begin
            s2_result.sum <= total_next;
            s2_result.id  <= s1_id;
        end
    end

    assign src_tvalid = s2_valid;
    assign src_tdata  = s2_result.sum;
    assign src_tid    = s2_result.id;

endmodule

// File: hdl/tuple_fifo.sv
`timescale 1ns/1ps

// Show-ahead FIFO, head entry is on rd.data whenever rd.valid is high
module tuple_fifo #(
    parameter type payload_t = tuple_pkg::tuple_t,
    parameter int  DEPTH     = 8
) (
    input  logic          aclk,
    input  logic          reset,

    tuple_stream_if.slave  wr,
    tuple_stream_if.master rd
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    logic full;
    logic empty;
    logic wr_en;
    logic rd_en;

    assign full  = (count == DEPTH[PTR_W:0]);
    assign empty = (count == '0);

    // A read in the same cycle frees the slot for a write when full
    assign wr.ready = !full || rd.ready;
    assign wr_en    = wr.valid && wr.ready;

    assign rd.valid = !empty;
    assign rd.data  = mem[rd_ptr];
    assign rd_en    = rd.valid && rd.ready;

    // Storage
    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr.data;
        end
    end

    // Pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge aclk) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Occupancy
    always_ff @(posedge aclk) begin
        if (reset) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: hdl/tuple_pkg.sv
package tuple_pkg;

    // Tuple geometry
    localparam int TUPLE_FIELDS = 16;
    localparam int FIELD_W      = 32;
    localparam int BEAT_W       = TUPLE_FIELDS * FIELD_W;

    // Width of the tag taken from the stream ID
    localparam int ID_W = 6;

    // One tuple as unpacked from a host beat
    // Field i sits in beat bits 32i+31:32i, so fields[0] is the low word
    typedef struct packed {
        logic [ID_W-1:0]                          id;
        logic [TUPLE_FIELDS-1:0][FIELD_W-1:0]     fields;
    } tuple_t;

    // Reduced result, sum is modulo 2^FIELD_W
    typedef struct packed {
        logic [ID_W-1:0]    id;
        logic [FIELD_W-1:0] sum;
    } sum_t;

endpackage

// File: hdl/tuple_stream_if.sv
`timescale 1ns/1ps

// Valid/ready stream between blocks of the tuple path
// A transfer happens on a rising edge with valid and ready both high
interface tuple_stream_if #(
    parameter type payload_t = logic [31:0]
);

    logic     valid;
    logic     ready;
    payload_t data;

    // Upstream side, holds valid and data until taken
    modport master (
        output valid,
        output data,
        input  ready
    );

    // Downstream side
    modport slave (
        input  valid,
        input  data,
        output ready
    );

endinterface

// File: hdl/tuple_sum_top.sv
`timescale 1ns/1ps

// Tuple reduction for the host stream of the user-logic slot
// Host beat in, one tagged 32-bit sum out per beat
module tuple_sum_top #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                             aclk,
    input  logic                             reset,

    // Host sink stream
    input  logic                             sink_tvalid,
    output logic                             sink_tready,
    input  logic [tuple_pkg::BEAT_W-1:0]     sink_tdata,
    input  logic [tuple_pkg::ID_W-1:0]       sink_tid,

    // Host source stream
    output logic                             src_tvalid,
    input  logic                             src_tready,
    output logic [tuple_pkg::FIELD_W-1:0]    src_tdata,
    output logic [tuple_pkg::ID_W-1:0]       src_tid
);

    // Unpack slice to FIFO
    tuple_stream_if #(
        .payload_t (tuple_pkg::tuple_t)
    ) tuple_bus ();

    // FIFO head to adder tree
    tuple_stream_if #(
        .payload_t (tuple_pkg::tuple_t)
    ) fifo_bus ();

    tuple_unpack u_unpack (
        .aclk        (aclk),
        .reset       (reset),
        .sink_tvalid (sink_tvalid),
        .sink_tready (sink_tready),
        .sink_tdata  (sink_tdata),
        .sink_tid    (sink_tid),
        .tuples      (tuple_bus.master)
    );

    // Sets how many tuples can wait while the host stalls the result
    tuple_fifo #(
        .payload_t (tuple_pkg::tuple_t),
        .DEPTH     (FIFO_DEPTH)
    ) u_fifo (
        .aclk  (aclk),
        .reset (reset),
        .wr    (tuple_bus.slave),
        .rd    (fifo_bus.master)
    );

    tuple_adder u_adder (
        .aclk       (aclk),
        .reset      (reset),
        .tuples     (fifo_bus.slave),
        .src_tvalid (src_tvalid),
        .src_tready (src_tready),
        .src_tdata  (src_tdata),
        .src_tid    (src_tid)
    );

endmodule

// File: hdl/tuple_unpack.sv
`timescale 1ns/1ps

module tuple_unpack (
    input  logic                             aclk,
    input  logic                             reset,

    input  logic                             sink_tvalid,
    output logic                             sink_tready,
    input  logic [tuple_pkg::BEAT_W-1:0]     sink_tdata,
    input  logic [tuple_pkg::ID_W-1:0]       sink_tid,

    tuple_stream_if.master                   tuples
);

    tuple_pkg::tuple_t beat_tuple;
    tuple_pkg::tuple_t slice_data;
    logic              slice_full;
    logic              beat_take;

    // Cut the beat into fields, field 0 from the low word
    always_comb begin
        beat_tuple.id = sink_tid;
        for (int i = 0; i < tuple_pkg::TUPLE_FIELDS; i++) begin
            beat_tuple.fields[i] = sink_tdata[i*tuple_pkg::FIELD_W +: tuple_pkg::FIELD_W];
        end
    end

    // Slice takes a new beat when empty or when its entry leaves now
    assign sink_tready = !slice_full || tuples.ready;
    assign beat_take   = sink_tvalid && sink_tready;

    always_ff @(posedge aclk) begin
        if (reset) begin
            slice_full <= 1'b0;
        end else if (sink_tready) begin
            slice_full <= sink_tvalid;
        end
    end

    always_ff @(posedge aclk) begin
        if (beat_take) begin
            slice_data <= beat_tuple;
        end
    end

    assign tuples.valid = slice_full;
    assign tuples.data  = slice_data;

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

// Free-running clock, power-on reset and reset on request
module tb_clock_gen #(
    parameter real PERIOD_NS    = 10.0,
    parameter int  RESET_CYCLES = 5
) (
    input  logic reset_req,
    output logic aclk,
    output logic reset
);

    initial begin
        aclk = 1'b0;
        forever #(PERIOD_NS / 2.0) aclk = ~aclk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge aclk);
        reset <= 1'b0;
        forever begin
            @(posedge aclk);
            // A request seen on an edge starts a new reset pulse
            if (reset_req) begin
                reset <= 1'b1;
                repeat (RESET_CYCLES) @(posedge aclk);
                reset <= 1'b0;
            end
        end
    end

endmodule

// File: testbench/tb_tuple_sum.sv
`timescale 1ns/1ps

module tb_tuple_sum;

    localparam int FIFO_DEPTH = 8;
    localparam int CAPACITY   = FIFO_DEPTH + 3;
    localparam int FIELDS     = tuple_pkg::TUPLE_FIELDS;
    localparam int FIELD_W    = tuple_pkg::FIELD_W;
    localparam int BEAT_W     = tuple_pkg::BEAT_W;
    localparam int ID_W       = tuple_pkg::ID_W;

    // Tuples over all tests, sizes the watchdog
    localparam int TOTAL_TUPLES   = 1 + 200 + 4 + 300 + (CAPACITY + 1) + 30 + 20;
    localparam int TIMEOUT_CYCLES = TOTAL_TUPLES * 20 + 1000;

    localparam int KIND_RANDOM  = 0;
    localparam int KIND_COUNT   = 1;
    localparam int KIND_ONES    = 2;
    localparam int READY_HIGH   = 0;
    localparam int READY_LOW    = 1;
    localparam int READY_RANDOM = 2;

    logic               aclk;
    logic               reset;
    logic               reset_req;
    logic               sink_tvalid;
    logic               sink_tready;
    logic [BEAT_W-1:0]  sink_tdata;
    logic [ID_W-1:0]    sink_tid;
    logic               src_tvalid;
    logic               src_tready;
    logic [FIELD_W-1:0] src_tdata;
    logic [ID_W-1:0]    src_tid;

    tuple_pkg::sum_t    exp_q [$];
    logic [31:0]        lfsr_state = 32'd68500;
    string              test_name = "power-on";
    int                 ready_mode = READY_HIGH;
    int                 cycle = 0;
    int                 in_target;
    int                 in_offered;
    int                 in_taken;
    int                 out_seen;
    int                 error_count = 0;
    int                 test_errors_at_start;
    int                 tests_run = 0;
    int                 tests_failed = 0;
    int                 outputs_checked = 0;
    int                 last_in_cycle;
    int                 last_out_cycle;
    logic [FIELD_W-1:0] last_sum;
    logic [ID_W-1:0]    last_id;

    tb_clock_gen #(
        .PERIOD_NS    (10.0),
        .RESET_CYCLES (5)
    ) clock_gen (
        .reset_req (reset_req),
        .aclk      (aclk),
        .reset     (reset)
    );

    tuple_sum_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) uut (
        .aclk        (aclk),
        .reset       (reset),
        .sink_tvalid (sink_tvalid),
        .sink_tready (sink_tready),
        .sink_tdata  (sink_tdata),
        .sink_tid    (sink_tid),
        .src_tvalid  (src_tvalid),
        .src_tready  (src_tready),
        .src_tdata   (src_tdata),
        .src_tid     (src_tid)
    );

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return (state >> 1) ^ (state[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // Sixteen fields added, wrapping at 2^32
    function automatic logic [FIELD_W-1:0] reference_sum(input logic [BEAT_W-1:0] beat);
        logic [FIELD_W-1:0] total;
        total = '0;
        for (int i = 0; i < FIELDS; i++) begin
            total = total + beat[i*FIELD_W +: FIELD_W];
        end
        return total;
    endfunction

    function automatic logic [BEAT_W-1:0] fill_beat(input int kind);
        logic [BEAT_W-1:0] beat;
        for (int i = 0; i < FIELDS; i++) begin
            case (kind)
                KIND_COUNT: beat[i*FIELD_W +: FIELD_W] = 32'(i + 1);
                KIND_ONES:  beat[i*FIELD_W +: FIELD_W] = '1;
                default:    beat[i*FIELD_W +: FIELD_W] = random_bits(FIELD_W);
            endcase
        end
        return beat;
    endfunction

    // Counts the output transfer of this edge, then sets src_tready
    task automatic step();
        @(posedge aclk);
        if (!reset && src_tvalid && src_tready) begin
            out_seen++;
        end
        case (ready_mode)
            READY_LOW:    src_tready <= 1'b0;
            READY_RANDOM: src_tready <= random_bits(1) == 32'd1;
            default:      src_tready <= 1'b1;
        endcase
    endtask

    task automatic offer_beat(input int kind);
        logic [31:0] id_bits;
        sink_tvalid <= 1'b1;
        sink_tdata  <= fill_beat(kind);
        id_bits = (kind == KIND_COUNT) ? 32'd5 : random_bits(ID_W);
        sink_tid    <= id_bits[ID_W-1:0];
    endtask

    // Holds an offer until taken, then offers the next one if any remain
    task automatic stim_cycle(input int kind, input bit sparse);
        step();
        if (!reset && sink_tvalid && sink_tready) begin
            in_taken++;
        end
        if (!sink_tvalid || sink_tready) begin
            if (in_offered < in_target && (!sparse || random_bits(1) == 32'd1)) begin
                offer_beat(kind);
                in_offered++;
            end else begin
                sink_tvalid <= 1'b0;
            end
        end
    endtask

    task automatic send_tuples(input int count, input int kind, input bit sparse);
        in_target = in_target + count;
        while (in_taken < in_target) begin
            stim_cycle(kind, sparse);
        end
    endtask

    task automatic drain();
        while (out_seen < in_taken) begin
            step();
        end
        // Past the last edge, so its comparison has finished
        @(negedge aclk);
    endtask

    task automatic begin_test(input string name);
        test_name            = name;
        test_errors_at_start = error_count;
        in_target            = 0;
        in_offered           = 0;
        in_taken             = 0;
        out_seen             = 0;
    endtask

    task automatic end_test();
        step();
        if (exp_q.size() != 0) begin
            $display("%s: %0d expected results never came out", test_name, exp_q.size());
            error_count++;
        end
        tests_run++;
        if (error_count == test_errors_at_start) begin
            $display("test %-14s passed, %0d tuples", test_name, in_taken);
        end else begin
            tests_failed++;
            $display("test %-14s failed, %0d errors", test_name,
                     error_count - test_errors_at_start);
        end
        ready_mode = READY_HIGH;
    endtask

    always @(posedge aclk) begin
        cycle <= cycle + 1;
    end

    // Expected result for every accepted beat
    always @(posedge aclk) begin : record_inputs
        tuple_pkg::sum_t item;
        if (reset) begin
            exp_q.delete();
        end else if (sink_tvalid && sink_tready) begin
            item.sum = reference_sum(sink_tdata);
            item.id  = sink_tid;
            exp_q.push_back(item);
            last_in_cycle = cycle;
        end
    end

    always @(posedge aclk) begin : compare_outputs
        tuple_pkg::sum_t want;
        if (!reset && src_tvalid && src_tready) begin
            last_sum       = src_tdata;
            last_id        = src_tid;
            last_out_cycle = cycle;
            outputs_checked++;
            if (exp_q.size() == 0) begin
                $display("%s: result %h with ID %0d came out with no beat pending",
                         test_name, src_tdata, src_tid);
                error_count++;
            end else begin
                want = exp_q.pop_front();
                if (src_tdata !== want.sum) begin
                    $display("[FAIL] %s sum: expected %h, actual %h",
                             test_name, want.sum, src_tdata);
                    error_count++;
                end
                if (src_tid !== want.id) begin
                    $display("[FAIL] %s id: expected %0d, actual %0d",
                             test_name, want.id, src_tid);
                    error_count++;
                end
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge aclk);
        $display("Watchdog: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        reset_req   = 1'b0;
        sink_tvalid = 1'b0;
        sink_tdata  = '0;
        sink_tid    = '0;
        src_tready  = 1'b0;

        step();
        while (reset) begin
            step();
        end

        begin_test("single");
        send_tuples(1, KIND_COUNT, 1'b0);
        drain();
        end_test_checks_single: begin
            // Rise after edge k+3 is first sampled on edge k+4
            if (last_out_cycle - last_in_cycle - 1 != 3) begin
                $display("[FAIL] %s latency: expected %0d, actual %0d",
                         test_name, 3, last_out_cycle - last_in_cycle - 1);
                error_count++;
            end
            if (last_sum !== 32'd136) begin
                $display("[FAIL] %s sum: expected %0d, actual %0d", test_name, 136, last_sum);
                error_count++;
            end
            if (last_id !== 6'd5) begin
                $display("[FAIL] %s id: expected %0d, actual %0d", test_name, 5, last_id);
                error_count++;
            end
        end
        end_test();

        begin_test("stream");
        send_tuples(200, KIND_RANDOM, 1'b0);
        drain();
        end_test();

        begin_test("wrap");
        send_tuples(4, KIND_ONES, 1'b0);
        drain();
        if (last_sum !== 32'hFFFF_FFF0) begin
            $display("[FAIL] %s sum: expected %h, actual %h", test_name, 32'hFFFF_FFF0, last_sum);
            error_count++;
        end
        end_test();

        begin_test("back-pressure");
        ready_mode = READY_RANDOM;
        send_tuples(300, KIND_RANDOM, 1'b1);
        drain();
        end_test();

        // One beat more than fits, so the last stays on offer
        begin_test("capacity");
        ready_mode = READY_LOW;
        in_target  = CAPACITY + 1;
        repeat (CAPACITY * 4) begin
            stim_cycle(KIND_RANDOM, 1'b0);
        end
        if (in_taken != CAPACITY) begin
            $display("[FAIL] %s accepted: expected %0d, actual %0d",
                     test_name, CAPACITY, in_taken);
            error_count++;
        end
        ready_mode = READY_HIGH;
        while (in_taken < in_target) begin
            stim_cycle(KIND_RANDOM, 1'b0);
        end
        drain();
        end_test();

        begin_test("reset");
        ready_mode = READY_RANDOM;
        in_target  = 30;
        repeat (15) begin
            stim_cycle(KIND_RANDOM, 1'b0);
        end
        reset_req <= 1'b1;
        step();
        reset_req   <= 1'b0;
        sink_tvalid <= 1'b0;
        while (!reset) begin
            step();
        end
        while (reset) begin
            step();
        end
        if (src_tvalid !== 1'b0) begin
            $display("[FAIL] %s src_tvalid after reset: expected %b, actual %b",
                     test_name, 1'b0, src_tvalid);
            error_count++;
        end
        in_target  = 0;
        in_offered = 0;
        in_taken   = 0;
        out_seen   = 0;
        send_tuples(20, KIND_RANDOM, 1'b0);
        drain();
        end_test();

        $display("tests %0d, failed %0d, outputs checked %0d, errors %0d",
                 tests_run, tests_failed, outputs_checked, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/tuple_sum_properties.sv
`timescale 1ns/1ps

// Handshake properties at the host ports of tuple_sum_top
module tuple_sum_properties #(
    parameter int FIFO_DEPTH = 8
) (
    input logic                          aclk,
    input logic                          reset,
    input logic                          sink_tvalid,
    input logic                          sink_tready,
    input logic                          src_tvalid,
    input logic                          src_tready,
    input logic [tuple_pkg::FIELD_W-1:0] src_tdata,
    input logic [tuple_pkg::ID_W-1:0]    src_tid
);

    // Unpack slice, FIFO and two adder stages
    localparam int CAPACITY = FIFO_DEPTH + 3;

    int held;

    // Tuples accepted but not yet returned
    always_ff @(posedge aclk) begin
        if (reset) begin
            held <= 0;
        end else begin
            held <= held + int'(sink_tvalid && sink_tready) - int'(src_tvalid && src_tready);
        end
    end

    reset_clears_output: assert property (
        @(posedge aclk) reset |=> !src_tvalid
    ) else $error("src_tvalid high in the cycle after reset");

    output_holds_while_stalled: assert property (
        @(posedge aclk) disable iff (reset)
        src_tvalid && !src_tready |=> src_tvalid && $stable(src_tdata) && $stable(src_tid)
    ) else $error("src_tvalid or src payload changed while stalled");

    full_blocks_sink: assert property (
        @(posedge aclk) disable iff (reset)
        held == CAPACITY && !src_tready |-> !sink_tready
    ) else $error("sink_tready high with %0d tuples held and output stalled", held);

    never_overfilled: assert property (
        @(posedge aclk) disable iff (reset)
        held <= CAPACITY
    ) else $error("%0d tuples held, more than the pipeline can store", held);

endmodule

bind tuple_sum_top tuple_sum_properties #(
    .FIFO_DEPTH (FIFO_DEPTH)
) u_properties (
    .aclk        (aclk),
    .reset       (reset),
    .sink_tvalid (sink_tvalid),
    .sink_tready (sink_tready),
    .src_tvalid  (src_tvalid),
    .src_tready  (src_tready),
    .src_tdata   (src_tdata),
    .src_tid     (src_tid)
);
